// File: ras_config_regs.sv
`timescale 1ns/1ps

module ras_config_regs import ras_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  cfg_req_t    cfg,
  input  logic        mismatch,
  output logic [31:0] cfg_rdata,
  output logic        ena,
  output logic [31:0] spill_base,
  output logic [31:0] mismatch_count
);

  logic wr_ctrl;
  logic wr_base;
  logic wr_mismatch;

  assign wr_ctrl     = cfg.wr && (cfg.addr == cfg_ctrl_addr);
  assign wr_base     = cfg.wr && (cfg.addr == cfg_base_addr);
  assign wr_mismatch = cfg.wr && (cfg.addr == cfg_mismatch_addr);

  always_ff @(posedge clk) begin
    if (reset) begin
      ena            <= 1'b0;
      spill_base     <= '0;
      mismatch_count <= '0;
    end else begin
      if (wr_ctrl) begin
        ena <= cfg.wdata[0];
      end
      if (wr_base) begin
        spill_base <= cfg.wdata;
      end
      // A write to the counter clears it, any data
      if (wr_mismatch) begin
        mismatch_count <= '0;
      end else if (mismatch) begin
        mismatch_count <= mismatch_count + 32'd1;
      end
    end
  end

  always_comb begin
    case (cfg.addr)
      cfg_ctrl_addr:     cfg_rdata = {31'd0, ena};
      cfg_base_addr:     cfg_rdata = spill_base;
      cfg_mismatch_addr: cfg_rdata = mismatch_count;
      default:           cfg_rdata = '0;
    endcase
  end

endmodule

// File: ras_pkg.sv
package ras_pkg;

  // Core-side call/return report
  typedef struct packed {
    logic        call;
    logic        ret;
    logic [31:0] addr;
  } ras_event_t;

  typedef struct packed {
    logic full;
    logic empty;
    logic mismatch;
    logic ready;
    logic ena;
  } ras_status_t;

  // Register access, reads are combinational from addr
  typedef struct packed {
    logic        wr;
    logic [2:0]  addr;
    logic [31:0] wdata;
  } cfg_req_t;

  // Backing memory, byte address
  typedef struct packed {
    logic        rd;
    logic        wr;
    logic [31:0] addr;
    logic [31:0] wdata;
  } mem_req_t;

  typedef struct packed {
    logic        rdy;
    logic [31:0] rdata;
  } mem_rsp_t;

  localparam logic [2:0] cfg_ctrl_addr     = 3'd0;
  localparam logic [2:0] cfg_base_addr     = 3'd1;
  localparam logic [2:0] cfg_mismatch_addr = 3'd2;

endpackage

// File: ras_spill_engine.sv
`timescale 1ns/1ps

module ras_spill_engine import ras_pkg::*; #(
  parameter int depth       = 32,
  parameter int high_mark   = 24,
  parameter int low_mark    = 16,
  parameter int spill_words = 64
) (
  input  logic                       clk,
  input  logic                       reset,
  input  logic [$clog2(depth+1)-1:0] count,
  input  logic [31:0]                spill_base,
  input  ras_event_t                 evt,
  input  logic [31:0]                bottom_rdata,
  input  mem_rsp_t                   mem_rsp,
  output mem_req_t                   mem_req,
  output logic                       bottom_take,
  output logic                       bottom_put,
  output logic [31:0]                bottom_wdata,
  output logic                       spilled_any,
  output logic [15:0]                spill_count,
  output logic                       ready
);

  typedef enum logic [1:0] {
    st_idle,
    st_request,
    st_wait,
    st_commit
  } state_t;

  state_t      state;
  logic        fill_q;
  logic [31:0] addr_q;
  logic [31:0] data_q;
  logic        room;
  logic        go_spill;
  logic        go_fill;

  assign room        = (spill_count < 16'(spill_words));
  assign spilled_any = (spill_count != '0);

  // Start on the event edge itself so busy time stays at four cycles
  always_comb begin
    go_spill = 1'b0;
    go_fill  = 1'b0;
    if (evt.call) begin
      go_spill = room && (int'(count) + 1 >= high_mark);
    end else if (evt.ret) begin
      go_fill = spilled_any && (count != '0) && (int'(count) - 1 < low_mark);
    end else begin
      go_spill = room && (int'(count) >= high_mark);
      go_fill  = spilled_any && (int'(count) < low_mark);
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state       <= st_idle;
      fill_q      <= 1'b0;
      spill_count <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (go_spill || go_fill) begin
            state  <= st_request;
            fill_q <= !go_spill;
          end
        end
        st_request: state <= st_wait;
        st_wait: begin
          if (mem_rsp.rdy) begin
            state <= st_commit;
          end
        end
        st_commit: begin
          state <= st_idle;
          if (fill_q) begin
            spill_count <= spill_count - 16'd1;
          end else begin
            spill_count <= spill_count + 16'd1;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == st_idle) begin
      addr_q <= spill_base +
                {14'd0, (go_spill ? spill_count : spill_count - 16'd1), 2'b00};
    end
    if (state == st_wait && mem_rsp.rdy) begin
      data_q <= mem_rsp.rdata;
    end
  end

  assign ready        = (state == st_idle);
  assign bottom_take  = (state == st_commit) && !fill_q;
  assign bottom_put   = (state == st_commit) && fill_q;
  assign bottom_wdata = data_q;

  // Stack is frozen while busy so the bottom word holds
  assign mem_req = '{rd:    (state == st_request) && fill_q,
                     wr:    (state == st_request) && !fill_q,
                     addr:  addr_q,
                     wdata: bottom_rdata};

  a_one_outstanding: assert property (@(posedge clk) disable iff (reset)
    (mem_req.rd || mem_req.wr) |=> !(mem_req.rd || mem_req.wr) ##1 mem_rsp.rdy)
    else $error("memory request overlapped or rdy not two cycles later");

  a_event_when_ready: assert property (@(posedge clk) disable iff (reset)
    !ready |-> !(evt.call || evt.ret))
    else $error("event while spill or fill busy");

endmodule

// File: ras_spill_mem.sv
`timescale 1ns/1ps

module ras_spill_mem import ras_pkg::*; #(
  parameter int spill_words = 64
) (
  input  logic     clk,
  input  logic     reset,
  input  mem_req_t mem_req,
  output mem_rsp_t mem_rsp
);

  localparam int aw = (spill_words > 1) ? $clog2(spill_words) : 1;

  logic [31:0]   words [spill_words];
  logic [aw-1:0] index;
  // Two-stage delay line for rdy
  logic [1:0]    busy;
  logic [31:0]   rdata_s1;
  logic [31:0]   rdata_s2;

  assign index = mem_req.addr[aw+1:2];

  always_ff @(posedge clk) begin
    if (reset) begin
      busy <= '0;
    end else begin
      busy <= {busy[0], mem_req.rd | mem_req.wr};
    end
  end

  always_ff @(posedge clk) begin
    if (mem_req.wr) begin
      words[index] <= mem_req.wdata;
    end
    if (mem_req.rd) begin
      rdata_s1 <= words[index];
    end
    rdata_s2 <= rdata_s1;
  end

  assign mem_rsp = '{rdy: busy[1], rdata: rdata_s2};

endmodule

// File: ras_stack.sv
`timescale 1ns/1ps

module ras_stack import ras_pkg::*; #(
  parameter int depth = 32
) (
  input  logic                       clk,
  input  logic                       reset,
  input  ras_event_t                 evt,
  input  logic                       ena,
  input  logic                       spilled_any,
  input  logic                       bottom_take,
  input  logic                       bottom_put,
  input  logic [31:0]                bottom_wdata,
  output logic [31:0]                bottom_rdata,
  output logic [$clog2(depth+1)-1:0] count,
  output logic                       full,
  output logic                       empty,
  output logic                       mismatch
);

  localparam int aw = (depth > 1) ? $clog2(depth) : 1;
  localparam int cw = $clog2(depth + 1);

  logic [31:0]   entries [depth];
  // top_ptr is the next free slot, bot_ptr the oldest entry
  logic [aw-1:0] top_ptr;
  logic [aw-1:0] bot_ptr;
  logic [aw-1:0] top_prev;
  logic [aw-1:0] bot_prev;
  logic          push;
  logic          pop;

  function automatic logic [aw-1:0] ptr_inc(input logic [aw-1:0] p);
    return (p == aw'(depth - 1)) ? '0 : p + 1'b1;
  endfunction

  function automatic logic [aw-1:0] ptr_dec(input logic [aw-1:0] p);
    return (p == '0) ? aw'(depth - 1) : p - 1'b1;
  endfunction

  assign top_prev     = ptr_dec(top_ptr);
  assign bot_prev     = ptr_dec(bot_ptr);
  assign bottom_rdata = entries[bot_ptr];
  assign full         = (count == cw'(depth));
  assign empty        = (count == '0);

  assign push = ena && evt.call;
  assign pop  = ena && evt.ret && !empty;

  always_ff @(posedge clk) begin
    if (reset) begin
      top_ptr  <= '0;
      bot_ptr  <= '0;
      count    <= '0;
      mismatch <= 1'b0;
    end else begin
      // Empty with nothing in memory counts as a miss
      mismatch <= ena && evt.ret &&
                  (empty ? !spilled_any : (entries[top_prev] != evt.addr));

      if (push) begin
        top_ptr <= ptr_inc(top_ptr);
      end else if (pop) begin
        top_ptr <= top_prev;
      end

      if (bottom_take) begin
        bot_ptr <= ptr_inc(bot_ptr);
      end else if (bottom_put) begin
        bot_ptr <= bot_prev;
      end

      if (push || bottom_put) begin
        count <= count + 1'b1;
      end else if (pop || bottom_take) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      entries[top_ptr] <= evt.addr;
    end else if (bottom_put) begin
      entries[bot_prev] <= bottom_wdata;
    end
  end

  // Source must respect ready and send one strobe at a time
  a_single_strobe: assert property (@(posedge clk) disable iff (reset)
    !(evt.call && evt.ret))
    else $error("call and ret raised together");

  // The spill engine must keep room on chip
  a_no_push_full: assert property (@(posedge clk) disable iff (reset)
    push |-> !full)
    else $error("push while stack full");

  a_bottom_excl: assert property (@(posedge clk) disable iff (reset)
    !(bottom_take && bottom_put))
    else $error("bottom take and put together");

endmodule

// File: ras_subsystem.f
ras_pkg.sv
ras_config_regs.sv
ras_stack.sv
ras_spill_engine.sv
ras_spill_mem.sv
seg7_scanner.sv
ras_subsystem.sv
tb_ras_subsystem.sv

// File: ras_subsystem.sv
`timescale 1ns/1ps

module ras_subsystem import ras_pkg::*; #(
  parameter int depth       = 32,
  parameter int high_mark   = 24,
  parameter int low_mark    = 16,
  parameter int spill_words = 64,
  parameter int scan_div    = 1000
) (
  input  logic        clk,
  input  logic        reset,
  input  ras_event_t  evt,
  input  cfg_req_t    cfg,
  output logic [31:0] cfg_rdata,
  output ras_status_t status,
  output logic [7:0]  an,
  output logic [6:0]  seg
);

  localparam int cw = $clog2(depth + 1);

  ras_event_t    evt_act;
  logic          ena;
  logic [31:0]   spill_base;
  logic [31:0]   mismatch_count;
  logic [31:0]   bottom_rdata;
  logic [31:0]   bottom_wdata;
  logic [31:0]   debug_word;
  logic [cw-1:0] count;
  logic          full;
  logic          empty;
  logic          mismatch;
  logic          ready;
  logic          spilled_any;
  logic          bottom_take;
  logic          bottom_put;
  logic [15:0]   spill_count;
  mem_req_t      mem_req;
  mem_rsp_t      mem_rsp;

  // Engine only sees events the stack will act on
  assign evt_act = '{call: evt.call & ena, ret: evt.ret & ena, addr: evt.addr};

  ras_config_regs config_regs_i (
    .clk, .reset, .cfg, .mismatch, .cfg_rdata, .ena, .spill_base, .mismatch_count
  );

  ras_stack #(.depth(depth)) stack_i (
    .clk, .reset, .evt, .ena, .spilled_any, .bottom_take, .bottom_put,
    .bottom_wdata, .bottom_rdata, .count, .full, .empty, .mismatch
  );

  ras_spill_engine #(
    .depth(depth), .high_mark(high_mark), .low_mark(low_mark), .spill_words(spill_words)
  ) spill_engine_i (
    .clk, .reset, .count, .spill_base, .evt(evt_act), .bottom_rdata, .mem_rsp, .mem_req,
    .bottom_take, .bottom_put, .bottom_wdata, .spilled_any, .spill_count, .ready
  );

  ras_spill_mem #(.spill_words(spill_words)) spill_mem_i (
    .clk, .reset, .mem_req, .mem_rsp
  );

  // Mismatch count over total call depth
  assign debug_word = {mismatch_count[15:0], 16'(count) + spill_count};

  seg7_scanner #(.scan_div(scan_div)) scanner_i (
    .clk, .reset, .value(debug_word), .an, .seg
  );

  assign status = '{full: full, empty: empty, mismatch: mismatch, ready: ready, ena: ena};

endmodule

// File: seg7_scanner.sv
`timescale 1ns/1ps

module seg7_scanner #(
  parameter int scan_div = 1000
) (
  input  logic        clk,
  input  logic        reset,
  input  logic [31:0] value,
  output logic [7:0]  an,
  output logic [6:0]  seg
);

  localparam int pw = (scan_div > 1) ? $clog2(scan_div) : 1;

  logic [pw-1:0] prescale;
  logic          step;
  logic [2:0]    digit;
  logic [3:0]    nibble;

  assign step = (prescale == pw'(scan_div - 1));

  always_ff @(posedge clk) begin
    if (reset) begin
      prescale <= '0;
      digit    <= '0;
    end else if (step) begin
      prescale <= '0;
      digit    <= digit + 3'd1;
    end else begin
      prescale <= prescale + 1'b1;
    end
  end

  // One anode low at a time, digit 0 on an[0]
  assign an     = ~(8'd1 << digit);
  assign nibble = value[{digit, 2'b00} +: 4];

  // Active low, segment a in the msb
  always_comb begin
    case (nibble)
      4'h0:    seg = 7'b0000001;
      4'h1:    seg = 7'b1001111;
      4'h2:    seg = 7'b0010010;
      4'h3:    seg = 7'b0000110;
      4'h4:    seg = 7'b1001100;
      4'h5:    seg = 7'b0100100;
      4'h6:    seg = 7'b0100000;
      4'h7:    seg = 7'b0001111;
      4'h8:    seg = 7'b0000000;
      4'h9:    seg = 7'b0000100;
      4'ha:    seg = 7'b0001000;
      4'hb:    seg = 7'b1100000;
      4'hc:    seg = 7'b0110001;
      4'hd:    seg = 7'b1000010;
      4'he:    seg = 7'b0110000;
      4'hf:    seg = 7'b0111000;
      default: seg = 7'b1111111;
    endcase
  end

endmodule

// File: tb_ras_subsystem.sv
`timescale 1ns/1ps

module tb_ras_subsystem import ras_pkg::*; ();

  localparam int high_mark = 6;
  localparam int scan_div  = 4;

  // Hex digit patterns active low with segment a in the msb
  localparam logic [6:0] seg_table [16] = '{
    7'h01, 7'h4f, 7'h12, 7'h06, 7'h4c, 7'h24, 7'h20, 7'h0f,
    7'h00, 7'h04, 7'h08, 7'h60, 7'h31, 7'h42, 7'h30, 7'h38
  };

  logic        clk = 1'b0;
  logic        reset;
  ras_event_t  evt;
  cfg_req_t    cfg;
  logic [31:0] cfg_rdata;
  ras_status_t status;
  logic [7:0]  an;
  logic [6:0]  seg;

  // Unbounded reference model stack
  logic [31:0] model [$];
  int          model_mm = 0;
  bit          model_ena = 1'b0;
  int          errors = 0;
  int          checks = 0;
  int          events_issued = 0;
  int          cycles = 0;
  bit          saw_busy = 1'b0;
  bit          monitor_on = 1'b0;

  ras_subsystem #(
    .depth(8), .high_mark(high_mark), .low_mark(3), .spill_words(32), .scan_div(scan_div)
  ) ras_subsystem_i (
    .clk, .reset, .evt, .cfg, .cfg_rdata, .status, .an, .seg
  );

  always #20 clk = ~clk;

  task automatic expect_true(input bit ok, input string msg);
    checks++;
    assert (ok) else begin
      $display("Error at %0t: %s", $time, msg);
      errors++;
    end
  endtask

  task automatic send_event(input bit call, input logic [31:0] addr, input bit exp_mm);
    while (!status.ready) begin
      saw_busy = 1'b1;
      @(negedge clk);
    end
    evt = '{call: call, ret: !call, addr: addr};
    events_issued++;
    @(negedge clk);
    evt = '{call: 1'b0, ret: 1'b0, addr: '0};
    expect_true(status.mismatch == exp_mm, "mismatch flag after event");
  endtask

  task automatic do_call(input logic [31:0] addr);
    send_event(1'b1, addr, 1'b0);
    if (model_ena) begin
      model.push_back(addr);
    end
  endtask

  task automatic do_ret(input logic [31:0] addr);
    bit miss;
    miss = model_ena && (model.size() == 0 || model[$] != addr);
    send_event(1'b0, addr, miss);
    if (model_ena && model.size() != 0) begin
      void'(model.pop_back());
    end
    if (miss) begin
      model_mm++;
    end
    if (model_ena && model.size() == 0) begin
      expect_true(status.empty, "empty not set at model depth zero");
    end
  endtask

  task automatic write_cfg(input logic [2:0] addr, input logic [31:0] data);
    cfg = '{wr: 1'b1, addr: addr, wdata: data};
    @(negedge clk);
    cfg = '{wr: 1'b0, addr: addr, wdata: '0};
  endtask

  task automatic read_cfg(input logic [2:0] addr, output logic [31:0] data);
    cfg = '{wr: 1'b0, addr: addr, wdata: '0};
    @(negedge clk);
    data = cfg_rdata;
  endtask

  task automatic set_enable(input bit on);
    write_cfg(cfg_ctrl_addr, {31'd0, on});
    model_ena = on;
    expect_true(status.ena == on, "ena does not follow control write");
  endtask

  task automatic check_display(input int n_cycles);
    logic [31:0] word;
    int k;
    int prev_k;
    int steps;
    word = {16'(model_mm), 16'(model.size())};
    prev_k = -1;
    steps = 0;
    repeat (n_cycles) begin
      @(negedge clk);
      k = -1;
      for (int i = 0; i < 8; i++) begin
        if (!an[i]) k = i;
      end
      if (k >= 0) begin
        expect_true(seg == seg_table[word[4*k +: 4]], "segment pattern for active digit");
        if (prev_k >= 0 && k != prev_k) begin
          expect_true(k == (prev_k + 1) % 8, "digit order");
          steps++;
        end
        prev_k = k;
      end
    end
    expect_true(steps >= n_cycles / scan_div - 1 && steps <= n_cycles / scan_div,
                "digit advance rate");
  endtask

  // Checked on every cycle once out of reset
  always @(negedge clk) begin
    if (monitor_on) begin
      expect_true($countones(~an) == 1, "anode not one-cold");
      expect_true(!status.full, "full flag raised");
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > 200 * events_issued + 2000) begin
      $display("Timeout: run still going after %0d cycles with %0d events issued",
               cycles, events_issued);
      $display("Checks: %0d, errors: %0d", checks, errors);
      $display("Result: FAILED");
      $finish;
    end
  end

  initial begin
    logic [31:0] data;
    void'($urandom(32'ha16b_4090));
    reset = 1'b1;
    evt   = '0;
    cfg   = '0;
    repeat (10) @(negedge clk);
    expect_true(!status.mismatch && status.ready && status.empty && !status.ena,
                "status after reset");
    expect_true(an == 8'hfe, "digit 0 not selected after reset");
    reset = 1'b0;
    monitor_on = 1'b1;
    read_cfg(cfg_mismatch_addr, data);
    expect_true(data == 32'd0, "mismatch count after reset");
    write_cfg(cfg_base_addr, 32'h0000_0100);
    set_enable(1'b1);

    // Shallow random nesting with correct targets
    for (int i = 0; i < 60; i++) begin
      if (model.size() == 0 || (model.size() < high_mark - 1 && $urandom_range(1, 0) == 1)) begin
        do_call($urandom);
      end else begin
        do_ret(model[$]);
      end
    end
    while (model.size() != 0) begin
      do_ret(model[$]);
    end

    // Wrong target then return on empty
    repeat (3) do_call($urandom);
    do_ret(~model[$]);
    do_ret(model[$]);
    do_ret(model[$]);
    do_ret($urandom);
    read_cfg(cfg_mismatch_addr, data);
    expect_true(data == model_mm, "mismatch count read-back");
    write_cfg(cfg_mismatch_addr, 32'd0);
    model_mm = 0;
    read_cfg(cfg_mismatch_addr, data);
    expect_true(data == 32'd0, "mismatch count after clear");

    // Deep recursion through the backing memory
    saw_busy = 1'b0;
    repeat (20) do_call($urandom);
    expect_true(saw_busy, "ready never dropped during calls");
    while (!status.ready) @(negedge clk);
    saw_busy = 1'b0;
    repeat (20) do_ret(model[$]);
    expect_true(saw_busy, "ready never dropped during returns");
    read_cfg(cfg_mismatch_addr, data);
    expect_true(data == 32'd0, "mismatch count changed by recursion");

    set_enable(1'b0);
    repeat (4) begin
      do_call($urandom);
      expect_true(status.empty, "call pushed while disabled");
      do_ret($urandom);
      expect_true(status.empty, "empty dropped while disabled");
    end
    set_enable(1'b1);

    // Display of mismatch count over depth while events idle
    do_ret($urandom);
    repeat (3) do_call($urandom);
    check_display(16 * scan_div);
    repeat (3) do_ret(model[$]);

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule
